// ==== source/paint_pkg.sv ====
`default_nettype none

package paint_pkg;

  // ****************************************
  // Widths
  // ****************************************
  localparam int coord_w   = 6;                    // 64 x 64 canvas
  localparam int pix_w     = 8;
  localparam int key_w     = 8;
  localparam int state_w   = 4;
  localparam int fb_addr_w = 2 * coord_w + 1;      // Bank bit on top

  // ASCII key codes
  localparam logic [key_w-1:0] key_c     = 8'h43;
  localparam logic [key_w-1:0] key_enter = 8'h0D;

  // Cursor box outline
  localparam int cursor_side   = 4;
  localparam int cursor_pixels = 4 * (cursor_side - 1);
  localparam int cursor_idx_w  = $clog2(cursor_pixels);
  localparam logic [cursor_idx_w-1:0] cursor_idx_last = cursor_idx_w'(cursor_pixels - 1);
  localparam logic [coord_w-1:0] cursor_last = coord_w'(cursor_side - 1);

  localparam logic [pix_w-1:0] cursor_color         = 8'hFF;
  localparam logic [pix_w-1:0] palette_cursor_color = 8'hE3;

  // ****************************************
  // Controller state codes
  // ****************************************
  localparam logic [state_w-1:0] st_start           = 4'b0000;
  localparam logic [state_w-1:0] st_init            = 4'b0001;
  localparam logic [state_w-1:0] st_check_c         = 4'b0010;
  localparam logic [state_w-1:0] st_check_enter     = 4'b0011;
  localparam logic [state_w-1:0] st_cursor_pal      = 4'b0100;
  localparam logic [state_w-1:0] st_check_enter_pal = 4'b0101;
  localparam logic [state_w-1:0] st_change_color    = 4'b0110;
  localparam logic [state_w-1:0] st_draw_cursor     = 4'b0111;
  localparam logic [state_w-1:0] st_paint           = 4'b1000;

  // One pixel byte, seen as RGB 3-3-2 or as a palette cell
  typedef union packed {
    struct packed {
      logic [2:0] red;
      logic [2:0] green;
      logic [1:0] blue;
    } rgb;
    struct packed {
      logic [3:0] row;                             // From y
      logic [3:0] col;                             // From x
    } pal;
  } pixel_u;

endpackage

`default_nettype wire

// ==== source/key_latch.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_latch import paint_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [key_w-1:0] key_code,
  input  logic             key_strobe,
  input  logic             rst_check,
  output logic             w_c,
  output logic             w_enter
);

  logic             valid;
  logic [key_w-1:0] code_q;

  // ****************************************
  // Pending key
  // ****************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (key_strobe) begin
      valid <= 1'b1;                               // New key beats a consume
    end else if (rst_check) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (key_strobe) begin
      code_q <= key_code;
    end
  end

  // Decoded levels, held until consumed
  assign w_c     = valid && (code_q == key_c);
  assign w_enter = valid && (code_q == key_enter);

endmodule

`default_nettype wire

// ==== source/cursor_sprite.sv ====
`timescale 1ns/10ps
`default_nettype none

module cursor_sprite import paint_pkg::*; #(
  parameter logic [pix_w-1:0] sprite_color = cursor_color
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  output logic [coord_w-1:0] dx,
  output logic [coord_w-1:0] dy,
  output logic [pix_w-1:0]   px_data,
  output logic               done
);

  logic [cursor_idx_w-1:0] idx;
  logic [coord_w-1:0]      i;

  // ****************************************
  // Outline pixel counter
  // ****************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      idx <= '0;
    end else if (!start || done) begin
      idx <= '0;                                   // Ready for the next pass
    end else begin
      idx <= idx + 1'b1;
    end
  end

  assign done = start && (idx == cursor_idx_last);

  assign i = coord_w'(idx);

  // Walk clockwise: top row, right column down, bottom row back, left column up
  always_comb begin
    if (idx < cursor_idx_w'(cursor_side)) begin
      dx = i;
      dy = '0;
    end else if (idx < cursor_idx_w'(2 * cursor_side - 1)) begin
      dx = cursor_last;
      dy = i - cursor_last;
    end else if (idx < cursor_idx_w'(3 * cursor_side - 2)) begin
      dx = coord_w'(3 * (cursor_side - 1)) - i;
      dy = cursor_last;
    end else begin
      dx = '0;
      dy = coord_w'(4 * (cursor_side - 1)) - i;
    end
  end

  assign px_data = start ? sprite_color : '0;      // Blank when idle

endmodule

`default_nettype wire

// ==== source/paint_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module paint_ctrl import paint_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               init,
  input  logic [coord_w-1:0] in_x,
  input  logic [coord_w-1:0] in_y,
  input  logic               w_c,
  input  logic               w_enter,
  input  logic               cursor_done,
  input  logic               cursor_pal_done,
  input  logic [pix_w-1:0]   px_data_cursor,
  input  logic [pix_w-1:0]   px_data_cursor_pal,
  input  logic [coord_w-1:0] cursor_dx,
  input  logic [coord_w-1:0] cursor_dy,
  input  logic [coord_w-1:0] pal_dx,
  input  logic [coord_w-1:0] pal_dy,
  output logic [coord_w-1:0] out_x,
  output logic [coord_w-1:0] out_y,
  output logic               we,
  output logic               bank,
  output logic [coord_w-1:0] wr_x,
  output logic [coord_w-1:0] wr_y,
  output logic [pix_w-1:0]   wr_data,
  output logic               rst_check,
  output logic               cursor_s,
  output logic               cursor_pal_s,
  output logic               busy
);

  logic [state_w-1:0] state;
  pixel_u             color_q;
  pixel_u             color_next;

  // Palette cell under the coordinates
  always_comb begin
    color_next.pal.row = in_y[3:0];
    color_next.pal.col = in_x[3:0];
  end

  // ****************************************
  // State register
  // ****************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_start;
      color_q <= '0;
      out_x   <= '0;
      out_y   <= '0;
    end else begin
      case (state)
        st_start:       state <= init ? st_init : st_start;
        st_init: begin
          out_x <= in_x;                           // Latch the point
          out_y <= in_y;
          state <= st_check_c;
        end
        st_check_c:     state <= w_c ? st_cursor_pal : st_check_enter;
        st_check_enter: state <= w_enter ? st_paint : st_draw_cursor;
        st_paint:       state <= st_init;
        st_draw_cursor: state <= cursor_done ? st_init : st_draw_cursor;
        st_cursor_pal:  state <= cursor_pal_done ? st_check_enter_pal : st_cursor_pal;
        st_check_enter_pal: begin
          state <= w_enter ? st_change_color : st_init;
        end
        st_change_color: begin
          color_q <= color_next;
          state   <= st_init;
        end
        default: begin
          color_q <= '0;
          state   <= st_start;
        end
      endcase
    end
  end

  // ****************************************
  // Output decode
  // ****************************************
  always_comb begin
    we           = 1'b0;
    bank         = 1'b0;
    cursor_s     = 1'b0;
    cursor_pal_s = 1'b0;
    rst_check    = 1'b0;
    wr_x         = out_x;
    wr_y         = out_y;
    wr_data      = color_q;
    case (state)
      st_start:        rst_check = 1'b1;
      st_paint: begin
        we        = 1'b1;                          // Plain point, paint colour
        rst_check = 1'b1;
      end
      st_draw_cursor: begin
        we       = 1'b1;
        cursor_s = 1'b1;
        wr_x     = out_x + cursor_dx;
        wr_y     = out_y + cursor_dy;
        wr_data  = px_data_cursor;
      end
      st_cursor_pal: begin
        we           = 1'b1;
        bank         = 1'b1;                       // Palette bank
        cursor_pal_s = 1'b1;
        wr_x         = out_x + pal_dx;
        wr_y         = out_y + pal_dy;
        wr_data      = px_data_cursor_pal;
        // Drop the C on the last pixel; an Enter that overwrote it is kept
        rst_check    = cursor_pal_done && w_c;
      end
      st_change_color: rst_check = 1'b1;
      st_init, st_check_c, st_check_enter, st_check_enter_pal: begin
        rst_check = 1'b0;
      end
      default:         rst_check = 1'b1;
    endcase
  end

  assign busy = (state != st_start);

endmodule

`default_nettype wire

// ==== source/frame_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_buffer import paint_pkg::*; (
  input  logic               clk,
  input  logic               we,
  input  logic               bank,
  input  logic [coord_w-1:0] wr_x,
  input  logic [coord_w-1:0] wr_y,
  input  logic [pix_w-1:0]   wr_data,
  input  logic               rd_bank,
  input  logic [coord_w-1:0] rd_x,
  input  logic [coord_w-1:0] rd_y,
  output logic [pix_w-1:0]   rd_data
);

  // Bank 0 is the canvas, bank 1 the palette
  logic [pix_w-1:0] mem [0:(2**fb_addr_w)-1];

  logic [fb_addr_w-1:0] wr_addr;
  logic [fb_addr_w-1:0] rd_addr;

  // Row major, x in the low bits
  assign wr_addr = {bank, wr_y, wr_x};
  assign rd_addr = {rd_bank, rd_y, rd_x};

  // ****************************************
  // Write port
  // ****************************************
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ****************************************
  // Read port
  // ****************************************
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];                       // One cycle of latency
  end

endmodule

`default_nettype wire

// ==== source/paint_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module paint_top import paint_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               init,
  input  logic [key_w-1:0]   key_code,
  input  logic               key_strobe,
  input  logic [coord_w-1:0] in_x,
  input  logic [coord_w-1:0] in_y,
  input  logic               rd_bank,
  input  logic [coord_w-1:0] rd_x,
  input  logic [coord_w-1:0] rd_y,
  output logic [pix_w-1:0]   rd_data,
  output logic               busy
);

  logic               w_c;
  logic               w_enter;
  logic               rst_check;
  logic               cursor_s;
  logic               cursor_pal_s;
  logic               cursor_done;
  logic               cursor_pal_done;
  logic [coord_w-1:0] cursor_dx;
  logic [coord_w-1:0] cursor_dy;
  logic [coord_w-1:0] pal_dx;
  logic [coord_w-1:0] pal_dy;
  logic [pix_w-1:0]   px_data_cursor;
  logic [pix_w-1:0]   px_data_cursor_pal;
  logic               we;
  logic               bank;
  logic [coord_w-1:0] wr_x;
  logic [coord_w-1:0] wr_y;
  logic [pix_w-1:0]   wr_data;

  key_latch key_latch0 (
    .clk(clk), .rst(rst),
    .key_code(key_code), .key_strobe(key_strobe),
    .rst_check(rst_check),
    .w_c(w_c), .w_enter(w_enter)
  );

  // Canvas cursor and palette cursor walkers
  cursor_sprite #(.sprite_color(cursor_color)) cursor0 (
    .clk(clk), .rst(rst), .start(cursor_s),
    .dx(cursor_dx), .dy(cursor_dy),
    .px_data(px_data_cursor), .done(cursor_done)
  );

  cursor_sprite #(.sprite_color(palette_cursor_color)) pal_cursor0 (
    .clk(clk), .rst(rst), .start(cursor_pal_s),
    .dx(pal_dx), .dy(pal_dy),
    .px_data(px_data_cursor_pal), .done(cursor_pal_done)
  );

  paint_ctrl paint_ctrl0 (
    .clk(clk), .rst(rst), .init(init),
    .in_x(in_x), .in_y(in_y),
    .w_c(w_c), .w_enter(w_enter),
    .cursor_done(cursor_done), .cursor_pal_done(cursor_pal_done),
    .px_data_cursor(px_data_cursor), .px_data_cursor_pal(px_data_cursor_pal),
    .cursor_dx(cursor_dx), .cursor_dy(cursor_dy),
    .pal_dx(pal_dx), .pal_dy(pal_dy),
    .out_x(), .out_y(),                            // Latched point stays internal
    .we(we), .bank(bank),
    .wr_x(wr_x), .wr_y(wr_y), .wr_data(wr_data),
    .rst_check(rst_check),
    .cursor_s(cursor_s), .cursor_pal_s(cursor_pal_s),
    .busy(busy)
  );

  frame_buffer frame_buffer0 (
    .clk(clk), .we(we), .bank(bank),
    .wr_x(wr_x), .wr_y(wr_y), .wr_data(wr_data),
    .rd_bank(rd_bank), .rd_x(rd_x), .rd_y(rd_y),
    .rd_data(rd_data)
  );

endmodule

`default_nettype wire

// ==== sim/paint_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module paint_assert import paint_pkg::*; (
  input logic               clk,
  input logic               rst,
  input logic [state_w-1:0] state,
  input logic               busy,
  input logic               we,
  input logic               cursor_s,
  input logic               cursor_pal_s
);

  logic in_draw;

  assign in_draw = (state == st_draw_cursor);

  // ****************************************
  // Controller output rules
  // ****************************************
  busy_decode: assert property (@(posedge clk) disable iff (rst)
    busy == (state != st_start))
    else $error("busy does not match the start state");

  we_sprites: assert property (@(posedge clk) disable iff (rst)
    !(we && cursor_s && cursor_pal_s))
    else $error("write with both sprite starts");

  one_sprite: assert property (@(posedge clk) disable iff (rst)
    !(cursor_s && cursor_pal_s))
    else $error("both sprite walkers started");

  // Cursor pass is one pixel per cycle
  draw_length: assert property (@(posedge clk) disable iff (rst)
    $rose(in_draw) |-> ##cursor_pixels !in_draw)
    else $error("cursor draw overran");

endmodule

bind paint_ctrl paint_assert assert0 (
  .clk(clk), .rst(rst), .state(state), .busy(busy),
  .we(we), .cursor_s(cursor_s), .cursor_pal_s(cursor_pal_s)
);

`default_nettype wire

// ==== sim/paint_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module paint_tb import paint_pkg::*; ();

  localparam int test_count  = 5;
  localparam int cycle_limit = test_count * 200;
  localparam int settle_len  = 32;                 // Longer than one cursor loop

  logic               clk;
  logic               rst;
  logic               init;
  logic [key_w-1:0]   key_code;
  logic               key_strobe;
  logic [coord_w-1:0] in_x;
  logic [coord_w-1:0] in_y;
  logic               rd_bank;
  logic [coord_w-1:0] rd_x;
  logic [coord_w-1:0] rd_y;
  logic [pix_w-1:0]   rd_data;
  logic               busy;

  integer             seed;
  int                 errors;
  int                 cycles;
  pixel_u             color_model;                 // Shadow colour register
  logic [coord_w-1:0] ox [0:cursor_pixels-1];
  logic [coord_w-1:0] oy [0:cursor_pixels-1];
  logic [coord_w-1:0] qx;
  logic [coord_w-1:0] qy;

  paint_top dut0 (
    .clk(clk), .rst(rst), .init(init),
    .key_code(key_code), .key_strobe(key_strobe),
    .in_x(in_x), .in_y(in_y),
    .rd_bank(rd_bank), .rd_x(rd_x), .rd_y(rd_y),
    .rd_data(rd_data), .busy(busy)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles", cycles);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  // ****************************************
  // Helpers
  // ****************************************
  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // Box outline: top row, right column down, bottom row back, left column up
  task automatic build_outline();
    int n;
    n = 0;
    for (int k = 0; k < cursor_side; k++) begin
      ox[n] = coord_w'(k);
      oy[n] = '0;
      n++;
    end
    for (int k = 1; k < cursor_side; k++) begin
      ox[n] = coord_w'(cursor_side - 1);
      oy[n] = coord_w'(k);
      n++;
    end
    for (int k = cursor_side - 2; k >= 0; k--) begin
      ox[n] = coord_w'(k);
      oy[n] = coord_w'(cursor_side - 1);
      n++;
    end
    for (int k = cursor_side - 2; k >= 1; k--) begin
      ox[n] = '0;
      oy[n] = coord_w'(k);
      n++;
    end
  endtask

  task automatic read_pixel(input logic b, input logic [coord_w-1:0] x,
                            input logic [coord_w-1:0] y, output logic [pix_w-1:0] v);
    @(posedge clk);
    rd_bank <= b;
    rd_x    <= x;
    rd_y    <= y;
    @(posedge clk);
    @(negedge clk);                                // Registered read settled
    v = rd_data;
  endtask

  task automatic press_key(input logic [key_w-1:0] k);
    @(posedge clk);
    key_code   <= k;
    key_strobe <= 1'b1;
    @(posedge clk);
    key_strobe <= 1'b0;
  endtask

  task automatic wait_state(input logic [state_w-1:0] s);
    int n;
    n = 0;
    @(negedge clk);
    while (dut0.paint_ctrl0.state !== s) begin
      n++;
      assert (n < 100) else begin
        $display("Controller never reached state %0d", s);
        $display("Simulation FAILED");
        $fatal(1);
      end
      @(negedge clk);
    end
  endtask

  task automatic move_to(input logic [coord_w-1:0] x, input logic [coord_w-1:0] y);
    @(posedge clk);
    in_x <= x;
    in_y <= y;
    repeat (settle_len) @(posedge clk);
  endtask

  // Steer away once the write is committed, so the cursor lands elsewhere
  task automatic park();
    @(posedge clk);
    in_x <= 6'd28;
    in_y <= 6'd52;
  endtask

  task automatic paint_at(input logic [coord_w-1:0] x, input logic [coord_w-1:0] y);
    move_to(x, y);
    press_key(key_enter);
    wait_state(st_paint);
    park();
  endtask

  task automatic check_outline(input logic b, input logic [coord_w-1:0] x,
                               input logic [coord_w-1:0] y, input logic [pix_w-1:0] exp);
    logic [pix_w-1:0] v;
    for (int k = 0; k < cursor_pixels; k++) begin
      read_pixel(b, x + ox[k], y + oy[k], v);
      check_value(b ? "rd_data bank 1" : "rd_data bank 0", v, exp);
    end
  endtask

  // ****************************************
  // Tests
  // ****************************************
  task automatic test_reset();
    logic [pix_w-1:0] a;
    logic [pix_w-1:0] b;
    check_value("busy", {7'd0, busy}, 8'd0);
    read_pixel(1'b0, 6'd40, 6'd10, a);
    repeat (10) @(posedge clk);
    read_pixel(1'b0, 6'd40, 6'd10, b);
    check_value("rd_data", b, a);
    check_value("busy", {7'd0, busy}, 8'd0);
  endtask

  task automatic test_paint_default();
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic [pix_w-1:0]   v;
    x = coord_w'($unsigned($random(seed)) % 8);
    y = coord_w'($unsigned($random(seed)) % 8);
    @(posedge clk);
    init <= 1'b1;
    move_to(x, y);
    read_pixel(1'b0, x, y, v);                     // Cursor sits on the point first
    check_value("rd_data", v, cursor_color);
    check_value("busy", {7'd0, busy}, 8'd1);
    press_key(key_enter);
    wait_state(st_paint);
    park();
    repeat (4) @(posedge clk);
    read_pixel(1'b0, x, y, v);
    check_value("rd_data", v, 8'h00);
  endtask

  task automatic test_color_change();
    logic [coord_w-1:0] px;
    logic [coord_w-1:0] py;
    logic [pix_w-1:0]   v;
    px = coord_w'(16 + $unsigned($random(seed)) % 8);
    py = coord_w'($unsigned($random(seed)) % 8);
    qx = coord_w'($unsigned($random(seed)) % 8);
    qy = coord_w'(16 + $unsigned($random(seed)) % 8);
    move_to(px, py);
    press_key(key_c);
    wait_state(st_cursor_pal);
    press_key(key_enter);                          // Arrives while the palette is drawn
    wait_state(st_change_color);
    color_model.pal.row = py[3:0];
    color_model.pal.col = px[3:0];
    park();
    paint_at(qx, qy);
    repeat (4) @(posedge clk);
    read_pixel(1'b0, qx, qy, v);
    check_value("rd_data", v, color_model);
  endtask

  task automatic test_idle_cursor();
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    x = coord_w'(32 + $unsigned($random(seed)) % 8);
    y = coord_w'(32 + $unsigned($random(seed)) % 8);
    move_to(x, y);
    repeat (20) @(posedge clk);
    check_outline(1'b0, x, y, cursor_color);
  endtask

  task automatic test_palette_bank();
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic [pix_w-1:0]   v;
    x = coord_w'(48 + $unsigned($random(seed)) % 8);
    y = coord_w'($unsigned($random(seed)) % 8);
    move_to(x, y);
    press_key(key_c);
    wait_state(st_cursor_pal);
    wait_state(st_check_enter_pal);
    check_outline(1'b1, x, y, palette_cursor_color);
    read_pixel(1'b0, qx, qy, v);                   // Earlier paint left alone
    check_value("rd_data", v, color_model);
  endtask

  initial begin
    seed       = 43;
    errors     = 0;
    clk        = 1'b0;
    rst        = 1'b1;
    init       = 1'b0;
    key_code   = '0;
    key_strobe = 1'b0;
    in_x       = '0;
    in_y       = '0;
    rd_bank    = 1'b0;
    rd_x       = '0;
    rd_y       = '0;
    color_model = '0;
    build_outline();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_paint_default();
    test_color_change();
    test_idle_cursor();
    test_palette_bank();
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
source/paint_pkg.sv
source/key_latch.sv
source/cursor_sprite.sv
source/paint_ctrl.sv
source/frame_buffer.sv
source/paint_top.sv
sim/paint_assert.sv
sim/paint_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the paint controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module paint_tb -o paint_sim \
  && out=$(./obj_dir/paint_sim) ; echo "$out" \
  && echo "$out" | grep -q "^Simulation PASSED$" \
  && exit 0 \
  || exit 1
